// File: build.f
rtl/dmm_cfg_pkg.sv
rtl/dmm_data_pkg.sv
rtl/adc_meas_if.sv
rtl/sample_acquisition_az.sv
rtl/bitstream_adc.sv
rtl/az_combiner.sv
rtl/result_credit_fifo.sv
rtl/dmm_acq_top.sv
tests/tb_dmm_acq.sv

// File: tests/tb_dmm_acq.sv
/*
  testbench for the auto-zero acquisition top level
  comparator and credit return come from an lcg and the reference model counts ones
  aperture and precharge only change while the sequencer is parked
*/
`timescale 1ns/1ns
`default_nettype none

module tb_dmm_acq;
  import dmm_cfg_pkg::*;
  import dmm_data_pkg::*;

  localparam logic [MUX_W-1:0] HI_CODE = 4'd5;      // az mux code for signal
  localparam logic [MUX_W-1:0] LO_CODE = 4'd10;     // az mux code for zero
  localparam int PC_MAIN     = 3;
  localparam int AP_MAIN     = 20;
  localparam int PC_RESTART  = 2;
  localparam int AP_RESTART  = 9;
  localparam int IDLE_CYCLES = 40;
  localparam int PARK_CYCLES = 150;                 // well above any aperture

  logic clk = 1'b0;
  logic reset_i = 1'b1;
  logic arm_i = 1'b0;
  logic comp_i = 1'b0;                              // driven by the model
  logic credit_i = 1'b0;                            // driven by the model
  logic [TIMER_W-1:0] precharge_cycles_i = PC_MAIN;
  logic [TIMER_W-1:0] aperture_cycles_i = AP_MAIN;
  logic [MUX_W-1:0]   azmux_hi_val_i = HI_CODE;
  logic [MUX_W-1:0]   azmux_lo_val_i = LO_CODE;
  logic [SW_PC_W-1:0] sw_pc_ctl_o;
  logic [MUX_W-1:0]   azmux_o;
  logic               adc_trig_o;
  logic [0:0]         status_o;
  logic               out_valid_o;
  az_result_t         out_data_o;

  // run control and bookkeeping
  string       test_name = "reset";
  int          error_count = 0;
  int          test_errors_start = 0;
  int          tests_done = 0;
  bit          armed_once = 1'b0;    // idle checks hold until the first arm
  bit          park_quiet = 1'b0;    // no trigger may start while set
  bit          credit_on = 1'b1;     // receiver returns credits
  bit [31:0]   lcg_state = 32'h41b1_d91b;

  // reference model state
  int          integ_left = 0;       // comparator samples still to count
  int          acc = 0;
  int          hi_cnt = 0;
  bit          pend_hi = 1'b0;       // hi counted, waiting for its lo
  bit          sample_hi = 1'b0;
  bit          expect_hi = 1'b1;     // phase of the next trigger
  bit          prev_seen = 1'b0;     // a sample was triggered since the last arm rise
  bit          prev_hi = 1'b0;       // phase of that sample
  bit          trig_q = 1'b0;
  bit          arm_q = 1'b0;
  int          exp_q [$];            // expected differences in order
  int          trig_count = 0;
  int          produced = 0;         // pairs closed by the model
  int          rx_count = 0;         // results seen at the output
  int          sent = 0;
  int          returned = 0;
  int          owed = 0;             // credits held by the receiver

  dmm_acq_top dmm_acq_top_i (
    .clk                (clk),
    .reset_i            (reset_i),
    .arm_i              (arm_i),
    .comp_i             (comp_i),
    .precharge_cycles_i (precharge_cycles_i),
    .aperture_cycles_i  (aperture_cycles_i),
    .azmux_hi_val_i     (azmux_hi_val_i),
    .azmux_lo_val_i     (azmux_lo_val_i),
    .credit_i           (credit_i),
    .sw_pc_ctl_o        (sw_pc_ctl_o),
    .azmux_o            (azmux_o),
    .adc_trig_o         (adc_trig_o),
    .status_o           (status_o),
    .out_valid_o        (out_valid_o),
    .out_data_o         (out_data_o)
  );

  always #4 clk = ~clk;               // 8 ns period

  ////////////////////////////////////////
  // helpers
  task automatic value_mismatch(input string what, input longint expected, input longint actual);
    $display("CHECK FAILED %s %s: expected %0d actual %0d", test_name, what, expected, actual);
    error_count++;
  endtask

  task automatic report_problem(input string what);
    $display("error in %s: %s", test_name, what);
    error_count++;
  endtask

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state >> 8;            // low lcg bits repeat quickly
  endfunction

  // ones per 16 comparator samples for the selected input
  function automatic int ones_density(input logic [MUX_W-1:0] code);
    if (code == HI_CODE)
      return 11;
    else if (code == LO_CODE)
      return 4;
    return 8;
  endfunction

  function automatic int result_cycles(input int pc, input int ap);
    return 4 * pc + 2 * ap + 40;      // one hi/lo pair with slack
  endfunction

  task automatic start_test(input string name);
    test_name = name;
    test_errors_start = error_count;
  endtask

  task automatic end_test();
    $display("test %-16s results %0d errors %0d", test_name, rx_count,
             error_count - test_errors_start);
    tests_done++;
  endtask

  // both return just after a rising edge where model counts are settled
  task automatic wait_results(input int target);
    do @(posedge clk); while (rx_count < target);
  endtask

  task automatic wait_triggers(input int target);
    do @(posedge clk); while (trig_count < target);
  endtask

  ////////////////////////////////////////
  // reference model, comparator and credit return on the falling edge
  task automatic check_result();
    int exp_diff;
    int act_diff;
    sent++;
    owed++;                           // receiver owes a credit back
    if (exp_q.size() == 0)
    begin
      report_problem("a result came out with no sample pair behind it");
      return;
    end
    exp_diff = exp_q.pop_front();
    act_diff = out_data_o.diff;       // diff is signed so it sign extends
    assert (act_diff == exp_diff)
      else value_mismatch("difference", exp_diff, act_diff);
    assert (out_data_o.seq == SEQ_W'(rx_count))
      else value_mismatch("sequence", rx_count % (1 << SEQ_W), out_data_o.seq);
    rx_count++;
  endtask

  task automatic close_sample();
    if (sample_hi)
    begin
      hi_cnt  = acc;                  // a later hi replaces it
      pend_hi = 1'b1;
    end
    else if (pend_hi)
    begin
      exp_q.push_back(hi_cnt - acc);
      produced++;
      pend_hi = 1'b0;
    end
  endtask

  always @(negedge clk)
  begin
    if (out_valid_o)
      check_result();
    assert (sent <= OUT_CREDITS + returned)
      else report_problem("more results presented than credits allow");

    // credit return with a random delay
    if (credit_on && owed > 0 && lcg_next() % 4 == 0)
    begin
      credit_i = 1'b1;
      owed--;
      returned++;
    end
    else
      credit_i = 1'b0;

    // comparator bit is counted if the adc will sample it
    comp_i = (lcg_next() % 16) < ones_density(azmux_o);
    if (integ_left > 0)
    begin
      acc += comp_i;
      integ_left--;
      if (integ_left == 0)
        close_sample();
    end

    if (adc_trig_o && !trig_q)        // trigger seen so the ack comes on the next edge
    begin
      integ_left = aperture_cycles_i;
      acc        = 0;
      sample_hi  = (azmux_o == HI_CODE);
      assert (sample_hi == expect_hi)
        else value_mismatch("trigger phase hi", expect_hi, sample_hi);
      if (prev_seen)                  // status shows the phase of the sample before
      begin
        assert (status_o[0] == prev_hi)
          else value_mismatch("status phase", prev_hi, status_o[0]);
      end
      prev_hi   = sample_hi;
      prev_seen = 1'b1;
      expect_hi = !sample_hi;
      trig_count++;
    end
    trig_q = adc_trig_o;

    if (arm_i && !arm_q)
    begin
      expect_hi = 1'b1;               // restart begins with hi
      prev_seen = 1'b0;
    end
    arm_q = arm_i;
  end

  ////////////////////////////////////////
  // protocol checks on the rising edge
  idle_trig: assert property (@(posedge clk) disable iff (reset_i)
    !armed_once |-> !adc_trig_o)
    else value_mismatch("trigger before arm", 0, 1);
  idle_out: assert property (@(posedge clk) disable iff (reset_i)
    !armed_once |-> !out_valid_o)
    else value_mismatch("output valid before arm", 0, 1);
  idle_sw: assert property (@(posedge clk) disable iff (reset_i)
    !armed_once |-> sw_pc_ctl_o == SW_PC_BOOT)
    else value_mismatch("switch before arm", SW_PC_BOOT, $sampled(sw_pc_ctl_o));
  hi_switch: assert property (@(posedge clk) disable iff (reset_i)
    ($rose(adc_trig_o) && azmux_o == HI_CODE) |-> sw_pc_ctl_o == SW_PC_SIGNAL)
    else value_mismatch("hi trigger switch", SW_PC_SIGNAL, $sampled(sw_pc_ctl_o));
  lo_switch: assert property (@(posedge clk) disable iff (reset_i)
    ($rose(adc_trig_o) && azmux_o == LO_CODE) |-> sw_pc_ctl_o == SW_PC_BOOT)
    else value_mismatch("lo trigger switch", SW_PC_BOOT, $sampled(sw_pc_ctl_o));
  mux_known: assert property (@(posedge clk) disable iff (reset_i)
    $rose(adc_trig_o) |-> (azmux_o == HI_CODE || azmux_o == LO_CODE))
    else report_problem("trigger with the az mux on neither hi nor lo");
  parked: assert property (@(posedge clk) disable iff (reset_i)
    park_quiet |-> !$rose(adc_trig_o))
    else report_problem("trigger issued while parked");

  ////////////////////////////////////////
  // watchdog sized from the test lengths
  initial
  begin : watchdog
    longint limit;
    limit = 2 * (IDLE_CYCLES + 16 * result_cycles(PC_MAIN, AP_MAIN)
                 + 2 * PARK_CYCLES + 3 * result_cycles(PC_RESTART, AP_RESTART)) + 200;
    repeat (limit) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", limit);
    $display("Test failed");
    $finish;
  end

  ////////////////////////////////////////
  // stimulus
  initial
  begin
    repeat (5) @(negedge clk);
    reset_i = 1'b0;

    start_test("idle_after_reset");
    repeat (IDLE_CYCLES) @(posedge clk);
    end_test();

    start_test("az_sequence");
    @(negedge clk);
    arm_i      = 1'b1;
    armed_once = 1'b1;
    wait_results(6);
    end_test();

    // receiver holds every credit for six pairs and then drains
    start_test("credit_stall");
    credit_on = 1'b0;
    wait_triggers(trig_count + 12);
    credit_on = 1'b1;
    wait_results(produced + 2);
    end_test();

    start_test("park_restart");
    @(negedge clk);
    arm_i = 1'b0;
    repeat (4) @(posedge clk);        // fall takes two edges to reach the fsm
    park_quiet = 1'b1;
    repeat (PARK_CYCLES) @(posedge clk);
    assert (exp_q.size() == 0)
      else report_problem("results still missing after the park");
    @(negedge clk);
    precharge_cycles_i = PC_RESTART;
    aperture_cycles_i  = AP_RESTART;
    park_quiet = 1'b0;
    arm_i      = 1'b1;
    wait_results(rx_count + 3);
    @(negedge clk);
    arm_i = 1'b0;
    repeat (PARK_CYCLES) @(posedge clk);
    assert (exp_q.size() == 0 && rx_count == produced)
      else report_problem("a result was lost before reaching the output");
    end_test();

    $display("summary: %0d tests, %0d results checked, %0d errors", tests_done, rx_count,
             error_count);
    if (error_count == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/dmm_acq_top.sv
/*
  auto-zero acquisition top level
  comp_i must already be synchronised to clk
  adc_trig_o mirrors the internal trigger for observation only
*/
`timescale 1ns/1ns
`default_nettype none

module dmm_acq_top (
  input  wire logic                              clk,
  input  wire logic                              reset_i,
  input  wire logic                              arm_i,
  input  wire logic                              comp_i,
  input  wire logic [dmm_cfg_pkg::TIMER_W-1:0]   precharge_cycles_i,
  input  wire logic [dmm_cfg_pkg::TIMER_W-1:0]   aperture_cycles_i,
  input  wire logic [dmm_cfg_pkg::MUX_W-1:0]     azmux_hi_val_i,
  input  wire logic [dmm_cfg_pkg::MUX_W-1:0]     azmux_lo_val_i,
  input  wire logic                              credit_i,
  output logic      [dmm_cfg_pkg::SW_PC_W-1:0]   sw_pc_ctl_o,
  output logic      [dmm_cfg_pkg::MUX_W-1:0]     azmux_o,
  output logic                                   adc_trig_o,
  output logic      [0:0]                        status_o,
  output logic                                   out_valid_o,
  output dmm_data_pkg::az_result_t               out_data_o
);
  import dmm_data_pkg::*;

  adc_meas_if  meas_if ();      // sequencer, adc and combiner share it
  logic        res_valid;
  az_result_t  res;

  assign adc_trig_o = meas_if.trig;

  sample_acquisition_az sample_acquisition_az_i (
    .clk                (clk),
    .reset_i            (reset_i),
    .arm_i              (arm_i),
    .precharge_cycles_i (precharge_cycles_i),
    .azmux_hi_val_i     (azmux_hi_val_i),
    .azmux_lo_val_i     (azmux_lo_val_i),
    .sw_pc_ctl_o        (sw_pc_ctl_o),
    .azmux_o            (azmux_o),
    .status_o           (status_o),
    .meas               (meas_if.seq)
  );

  bitstream_adc bitstream_adc_i (
    .clk               (clk),
    .reset_i           (reset_i),
    .comp_i            (comp_i),
    .aperture_cycles_i (aperture_cycles_i),
    .meas              (meas_if.adc)
  );

  az_combiner az_combiner_i (
    .clk         (clk),
    .reset_i     (reset_i),
    .meas        (meas_if.sink),
    .res_valid_o (res_valid),
    .res_o       (res)
  );

  result_credit_fifo result_credit_fifo_i (
    .clk         (clk),
    .reset_i     (reset_i),
    .in_valid_i  (res_valid),
    .in_data_i   (res),
    .credit_i    (credit_i),
    .out_valid_o (out_valid_o),
    .out_data_o  (out_data_o)
  );

endmodule

`default_nettype wire

// File: rtl/result_credit_fifo.sv
/*
  result fifo, FIFO_DEPTH entries, pushes are dropped while full
  one entry presented per cycle while non-empty and credits remain
  each credit_i cycle returns one credit, capped at OUT_CREDITS
*/
`timescale 1ns/1ns
`default_nettype none

module result_credit_fifo (
  input  wire logic                      clk,
  input  wire logic                      reset_i,
  input  wire logic                      in_valid_i,
  input  wire dmm_data_pkg::az_result_t  in_data_i,
  input  wire logic                      credit_i,      // one credit per high cycle
  output logic                           out_valid_o,
  output dmm_data_pkg::az_result_t       out_data_o
);
  import dmm_cfg_pkg::*;
  import dmm_data_pkg::*;

  az_result_t             mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0]  wr_ptr;
  logic [FIFO_PTR_W-1:0]  rd_ptr;
  logic [FIFO_FILL_W-1:0] fill;
  logic [CREDIT_W-1:0]    credits;      // sends still allowed
  logic [CREDIT_W-1:0]    credits_nxt;
  logic                   push;
  logic                   pop;

  assign push = in_valid_i && (fill != FIFO_DEPTH);
  assign pop  = (fill != '0) && (credits != '0);

  ////////////////////////////////////////
  // credit count
  always_comb
  begin
    credits_nxt = credits;
    case ({pop, credit_i})
      2'b10: credits_nxt = credits - 1'b1;
      2'b01:
        if (credits != OUT_CREDITS)
          credits_nxt = credits + 1'b1;   // saturate, extra returns ignored
      default: credits_nxt = credits;     // none, or spend and return together
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      fill        <= '0;
      credits     <= CREDIT_W'(OUT_CREDITS);
      out_valid_o <= 1'b0;
    end
    else
    begin
      credits     <= credits_nxt;
      out_valid_o <= pop;
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      fill <= fill + push - pop;
    end
  end

  ////////////////////////////////////////
  // storage and output register
  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= in_data_i;
    if (pop)
      out_data_o <= mem[rd_ptr];   // held between presentations
  end

endmodule

`default_nettype wire

// File: rtl/az_combiner.sv
/*
  pairs each hi count with the lo count after it, result is hi - lo
  a lo without a pending hi is dropped, a second hi replaces the first
*/
`timescale 1ns/1ns
`default_nettype none

module az_combiner (
  input  wire logic                      clk,
  input  wire logic                      reset_i,
  adc_meas_if.sink                       meas,
  output logic                           res_valid_o,    // one cycle per result
  output dmm_data_pkg::az_result_t       res_o
);
  import dmm_cfg_pkg::*;
  import dmm_data_pkg::*;

  logic [COUNT_W-1:0] hi_count;     // last hi sample
  logic               hi_pending;   // hi seen, waiting for its lo
  logic [SEQ_W-1:0]   seq_num;
  logic signed [COUNT_W:0] diff;

  // both counts are unsigned so zero-extend before subtracting
  assign diff = $signed({1'b0, hi_count}) - $signed({1'b0, meas.count});

  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      hi_pending  <= 1'b0;
      seq_num     <= '0;
      res_valid_o <= 1'b0;
    end
    else
    begin
      res_valid_o <= 1'b0;
      if (meas.done_pulse)
      begin
        if (meas.phase == PHASE_HI)
        begin
          hi_count   <= meas.count;
          hi_pending <= 1'b1;
        end
        else if (hi_pending)           // lo closes the pair
        begin
          res_o.diff  <= diff;
          res_o.seq   <= seq_num;
          res_valid_o <= 1'b1;
          seq_num     <= seq_num + 1'b1;   // wraps
          hi_pending  <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/bitstream_adc.sv
/*
  bitstream adc: counts comp_i ones on the aperture_cycles_i edges after a trigger ack
  aperture_cycles_i must be at least 1 and stable while integrating
  count stays valid until the next trigger is acknowledged
*/
`timescale 1ns/1ns
`default_nettype none

module bitstream_adc (
  input  wire logic                             clk,
  input  wire logic                             reset_i,
  input  wire logic                             comp_i,              // synchronised comparator
  input  wire logic [dmm_cfg_pkg::TIMER_W-1:0]  aperture_cycles_i,
  adc_meas_if.adc                               meas
);
  import dmm_cfg_pkg::*;

  typedef enum logic [1:0] {
    A_IDLE,
    A_INTEG,
    A_PUBLISH
  } adc_state_t;

  adc_state_t         state;
  logic [TIMER_W-1:0] aperture_left;   // samples still to take
  logic [COUNT_W-1:0] ones_acc;        // running ones count

  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      state           <= A_IDLE;
      meas.valid      <= 1'b1;         // idle reads as valid, nothing pending
      meas.done_pulse <= 1'b0;
    end
    else
    begin
      meas.done_pulse <= 1'b0;         // single cycle strobe

      case (state)
        A_IDLE:
          if (meas.trig)
          begin
            meas.valid    <= 1'b0;     // acknowledge edge
            aperture_left <= aperture_cycles_i;
            ones_acc      <= '0;
            state         <= A_INTEG;
          end

        A_INTEG:
        begin
          ones_acc      <= ones_acc + comp_i;
          aperture_left <= aperture_left - 1'b1;
          if (aperture_left <= 1)      // this edge takes the last sample
            state <= A_PUBLISH;
        end

        A_PUBLISH:
        begin
          meas.count      <= ones_acc;
          meas.valid      <= 1'b1;
          meas.done_pulse <= 1'b1;
          state           <= A_IDLE;
        end

        default:
          state <= A_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/sample_acquisition_az.sv
/*
  auto-zero sequencer: pre-charge switch, az mux, then adc trigger, hi/lo alternating
  every wait lasts about precharge_cycles_i + 1 clocks from one shared down-counter
  rising arm_i restarts from boot, falling arm_i parks with switches held
*/
`timescale 1ns/1ns
`default_nettype none

module sample_acquisition_az (
  input  wire logic                              clk,
  input  wire logic                              reset_i,
  input  wire logic                              arm_i,                // level, edges used
  input  wire logic [dmm_cfg_pkg::TIMER_W-1:0]   precharge_cycles_i,
  input  wire logic [dmm_cfg_pkg::MUX_W-1:0]     azmux_hi_val_i,      // mux code for signal
  input  wire logic [dmm_cfg_pkg::MUX_W-1:0]     azmux_lo_val_i,      // mux code for zero
  output logic      [dmm_cfg_pkg::SW_PC_W-1:0]   sw_pc_ctl_o,
  output logic      [dmm_cfg_pkg::MUX_W-1:0]     azmux_o,
  output logic      [0:0]                        status_o,            // bit 0 last phase
  adc_meas_if.seq                                meas
);
  import dmm_cfg_pkg::*;
  import dmm_data_pkg::*;

  typedef enum logic [3:0] {
    S_START,
    S_PC_BOOT,       // protect signal before the first hi
    S_PC_WAIT,
    S_HI_MUX,        // az mux to hi, signal still behind the pc switch
    S_HI_WAIT,
    S_SIG,           // pc switch to signal
    S_SIG_WAIT,
    S_HI_ACK,        // trig high, wait for valid low
    S_HI_MEAS,       // wait for valid high
    S_LO_BOOT,       // pc switch back to boot
    S_LO_BOOT_WAIT,
    S_LO_MUX,        // az mux to lo
    S_LO_WAIT,
    S_LO_ACK,
    S_LO_MEAS,
    S_PARK
  } seq_state_t;

  seq_state_t         state;
  logic [TIMER_W-1:0] count_down;    // shared by every settle wait
  logic [1:0]         arm_edge;      // {old, new}

  always_ff @(posedge clk)
  begin
    if (reset_i)
    begin
      state       <= S_PARK;           // nothing runs until an arm edge
      count_down  <= '0;
      arm_edge    <= '0;
      meas.trig   <= 1'b0;
      meas.phase  <= PHASE_LO;
      sw_pc_ctl_o <= SW_PC_BOOT;
      azmux_o     <= azmux_lo_val_i;
      status_o    <= 1'b0;
    end
    else
    begin
      count_down <= count_down - 1'b1;    // free running, reloaded on entry to a wait

      case (state)
        S_START:
        begin
          meas.trig <= 1'b0;
          state     <= S_PC_BOOT;
        end

        ////////////////////////////////////////
        // initial protect
        S_PC_BOOT:
        begin
          sw_pc_ctl_o <= SW_PC_BOOT;
          count_down  <= precharge_cycles_i;
          state       <= S_PC_WAIT;
        end
        S_PC_WAIT:
          if (count_down == '0)
            state <= S_HI_MUX;

        ////////////////////////////////////////
        // hi sample
        S_HI_MUX:
        begin
          azmux_o    <= azmux_hi_val_i;
          count_down <= precharge_cycles_i;    // lets the mux charge injection settle
          state      <= S_HI_WAIT;
        end
        S_HI_WAIT:
          if (count_down == '0)
            state <= S_SIG;
        S_SIG:
        begin
          sw_pc_ctl_o <= SW_PC_SIGNAL;
          count_down  <= precharge_cycles_i;   // offset between sig and boot settles
          state       <= S_SIG_WAIT;
        end
        S_SIG_WAIT:
          if (count_down == '0)
          begin
            meas.trig  <= 1'b1;
            meas.phase <= PHASE_HI;
            state      <= S_HI_ACK;
          end
        S_HI_ACK:
          if (!meas.valid)             // adc took the trigger
          begin
            meas.trig <= 1'b0;
            state     <= S_HI_MEAS;
          end
        S_HI_MEAS:
          if (meas.valid)
          begin
            status_o <= PHASE_HI;      // set after the result so it can be read with it
            state    <= S_LO_BOOT;
          end

        ////////////////////////////////////////
        // lo sample
        S_LO_BOOT:
        begin
          sw_pc_ctl_o <= SW_PC_BOOT;
          count_down  <= precharge_cycles_i;   // kept symmetric with the hi side
          state       <= S_LO_BOOT_WAIT;
        end
        S_LO_BOOT_WAIT:
          if (count_down == '0)
            state <= S_LO_MUX;
        S_LO_MUX:
        begin
          azmux_o    <= azmux_lo_val_i;
          count_down <= precharge_cycles_i;
          state      <= S_LO_WAIT;
        end
        S_LO_WAIT:
          if (count_down == '0)
          begin
            meas.trig  <= 1'b1;
            meas.phase <= PHASE_LO;
            state      <= S_LO_ACK;
          end
        S_LO_ACK:
          if (!meas.valid)
          begin
            meas.trig <= 1'b0;
            state     <= S_LO_MEAS;
          end
        S_LO_MEAS:
          if (meas.valid)
          begin
            status_o <= PHASE_LO;
            state    <= S_HI_MUX;      // next pair, no extra boot phase
          end

        S_PARK:
          ;                            // switches and mux hold

        default:
          state <= S_PARK;
      endcase

      // arm edges override whatever state is running
      arm_edge <= {arm_edge[0], arm_i};
      if (arm_edge == 2'b01)
        state <= S_START;
      else if (arm_edge == 2'b10)
      begin
        state     <= S_PARK;
        meas.trig <= 1'b0;             // no trigger left pending while parked
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/adc_meas_if.sv
/*
  trigger/valid handshake between sequencer, adc and combiner
  valid idles high; a low valid means the adc is busy with a trigger
*/
`timescale 1ns/1ns
`default_nettype none

interface adc_meas_if;
  import dmm_cfg_pkg::*;
  import dmm_data_pkg::*;

  logic               trig;          // sequencer requests a sample
  logic               valid;         // adc idle, count holds a result
  logic [COUNT_W-1:0] count;         // ones counted over the aperture
  phase_t             phase;         // tag of the current sample
  logic               done_pulse;    // one cycle, with the rise of valid

  modport seq  (output trig, output phase, input valid);
  modport adc  (input trig, output valid, output count, output done_pulse);
  modport sink (input count, input phase, input done_pulse);

endinterface

`default_nettype wire

// File: rtl/dmm_data_pkg.sv
/*
  sample and result records shared by the acquisition datapath
  diff is hi minus lo, one bit wider than a count so it never overflows
*/
`default_nettype none

package dmm_data_pkg;

  // which az phase a sample belongs to
  typedef enum logic {
    PHASE_LO = 1'b0,    // zero reference
    PHASE_HI = 1'b1     // signal
  } phase_t;

  // one zero-corrected reading, 33 bits
  typedef struct packed {
    logic signed [dmm_cfg_pkg::COUNT_W:0] diff;    // hi count - lo count
    logic [dmm_cfg_pkg::SEQ_W-1:0]        seq;     // increments per result
  } az_result_t;

endpackage

`default_nettype wire

// File: rtl/dmm_cfg_pkg.sv
/*
  configuration constants for the auto-zero acquisition front end
  counter widths limit precharge and aperture to 2^24-1 clocks
*/
`default_nettype none

package dmm_cfg_pkg;

  ////////////////////////////////////////
  // switch and mux codes
  localparam int SW_PC_W = 2;                              // pre-charge switch code width
  localparam logic [SW_PC_W-1:0] SW_PC_BOOT   = 2'b00;     // signal protected, boot drives
  localparam logic [SW_PC_W-1:0] SW_PC_SIGNAL = 2'b10;     // signal passed to the az mux
  localparam int MUX_W = 4;                                // az mux select code

  ////////////////////////////////////////
  // counters
  localparam int TIMER_W = 24;    // phase and aperture down-counters
  localparam int COUNT_W = 24;    // ones count from the bitstream adc
  localparam int SEQ_W   = 8;     // result sequence number, wraps

  ////////////////////////////////////////
  // result fifo and credits
  localparam int FIFO_DEPTH  = 8;                          // power of two
  localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);
  localparam int FIFO_FILL_W = $clog2(FIFO_DEPTH + 1);     // 0..FIFO_DEPTH
  localparam int OUT_CREDITS = 4;                          // credits held after reset
  localparam int CREDIT_W    = $clog2(OUT_CREDITS + 1);    // 0..OUT_CREDITS

endpackage

`default_nettype wire
